// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_lcd_top
FILELIST = lcd_draw.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: lcd_axi_slave.sv
// AXI4-Lite register slave, feeds drawing words to the graph buffer and returns status
module lcd_axi_slave
  import lcd_pkg::*;
(
  input  logic       pclk,
  input  logic       rst_n,

  input  lcd_addr_t  awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  lcd_word_t  wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,

  input  lcd_addr_t  araddr,
  input  logic       arvalid,
  output logic       arready,
  output lcd_word_t  rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,

  input  lcd_word_t  lcd_input_data,  // touch/input value from the panel side

  input  logic       full,            // buffer busy with a drawing
  output logic       push,
  output lcd_word_t  push_data
);

  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic wr_is_data;
  logic wr_mapped;
  logic wr_go;
  logic rd_go;

  assign wr_is_data = (awaddr == REG_DATA);
  assign wr_mapped = wr_is_data || (awaddr == REG_TOUCH) || (awaddr == REG_STATUS);

  // address and data are taken together
  // a data store waits while the buffer is busy or the last push is still in flight
  assign wr_go = awvalid && wvalid && (!bvalid || bready) &&
                 !(wr_is_data && (full || push));
  assign awready = wr_go;
  assign wready = wr_go;

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      bvalid <= 1'b0;
      bresp <= RESP_OKAY;
      push <= 1'b0;
    end else begin
      push <= wr_go && wr_is_data;  // one cycle after acceptance
      if (wr_go) begin
        bvalid <= 1'b1;
        bresp <= wr_mapped ? RESP_OKAY : RESP_SLVERR;
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (wr_go && wr_is_data) begin
      push_data <= wdata;
    end
  end

  // read side, one outstanding beat
  assign arready = !rvalid || rready;
  assign rd_go = arvalid && arready;

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      rvalid <= 1'b0;
    end else if (rd_go) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge pclk) begin
    if (rd_go) begin
      rresp <= RESP_OKAY;
      case (araddr)
        REG_DATA: rdata <= '0;  // write only
        REG_TOUCH: rdata <= lcd_input_data;
        REG_STATUS: rdata <= lcd_word_t'(full);
        default: begin
          rdata <= '0;
          rresp <= RESP_SLVERR;
        end
      endcase
    end
  end

endmodule

// File: lcd_draw.f
lcd_pkg.sv
lcd_axi_slave.sv
lcd_graph_buffer.sv
lcd_panel_writer.sv
lcd_top.sv
lcd_top_chk.sv
tb_lcd_top.sv

// File: lcd_graph_buffer.sv
// graph buffer, collects one drawing of seven words and paces its six commands to the writer
module lcd_graph_buffer
  import lcd_pkg::*;
#(
  parameter int GAP_CYCLES = 2
) (
  input  logic       pclk,
  input  logic       rst_n,

  input  logic       push,
  input  lcd_word_t  push_data,
  output logic       full,

  input  logic       write_ok,     // writer idle
  output logic       cmd_valid,
  output lcd_word_t  cmd_word,
  output pix_count_t pixel_count
);

  localparam int GW = $clog2(GAP_CYCLES + 2);
  localparam logic [2:0] LAST_FILL = 3'(GRAPH_WORDS - 1);
  localparam logic [2:0] LAST_CMD = 3'(GRAPH_WORDS - 2);

  buf_state_t state;
  lcd_word_t words [GRAPH_WORDS];
  logic [2:0] fill_idx;
  logic [2:0] disp_idx;
  logic [GW-1:0] gap_cnt;  // cycles since the last dispatch, saturating
  logic gap_done;

  assign gap_done = (gap_cnt == GW'(GAP_CYCLES));
  assign full = (state != FILL);
  assign cmd_valid = (state == DISPATCH) && write_ok && gap_done;
  assign cmd_word = words[disp_idx];
  assign pixel_count = words[GRAPH_WORDS-1];  // last store of a drawing

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state <= FILL;
      fill_idx <= '0;
      disp_idx <= '0;
      gap_cnt <= GW'(GAP_CYCLES);  // first command goes out at once
    end else begin
      if (cmd_valid) begin
        gap_cnt <= '0;
      end else if (!gap_done) begin
        gap_cnt <= gap_cnt + 1'b1;
      end

      case (state)
        FILL: begin
          if (push) begin
            if (fill_idx == LAST_FILL) begin
              fill_idx <= '0;
              state <= DISPATCH;
            end else begin
              fill_idx <= fill_idx + 3'd1;
            end
          end
        end
        DISPATCH: begin
          if (cmd_valid) begin
            if (disp_idx == LAST_CMD) begin
              disp_idx <= '0;
              state <= DRAIN;
            end else begin
              disp_idx <= disp_idx + 3'd1;
            end
          end
        end
        DRAIN: if (write_ok) state <= FILL;  // writer done with the last command
        default: state <= FILL;
      endcase
    end
  end

  always_ff @(posedge pclk) begin
    if (state == FILL && push) begin
      words[fill_idx] <= push_data;
    end else if (state == DRAIN && write_ok) begin
      for (int i = 0; i < GRAPH_WORDS; i++) begin
        words[i] <= '0;
      end
    end
  end

endmodule

// File: lcd_panel_writer.sv
// panel writer, turns command words into 8080 write cycles with pixel repeat
module lcd_panel_writer
  import lcd_pkg::*;
#(
  parameter int WR_CYCLES = 2
) (
  input  logic       pclk,
  input  logic       rst_n,

  input  logic       cmd_valid,
  input  lcd_word_t  cmd_word,
  input  pix_count_t pixel_count,
  output logic       write_ok,

  output logic       lcd_cs_n,
  output logic       lcd_rs,
  output logic       lcd_wr_n,
  output pix_data_t  lcd_data
);

  localparam int TW = $clog2(2 * WR_CYCLES);
  localparam logic [TW-1:0] T_LAST = TW'(2 * WR_CYCLES - 1);
  localparam logic [TW-1:0] T_HALF = TW'(WR_CYCLES);

  pw_state_t state;
  logic [TW-1:0] timer;   // position inside the current bus cycle
  pix_count_t reps;       // data cycles left, current one included
  pix_count_t first_reps;
  logic [7:0] cmd_q;
  pix_data_t param_q;
  logic slot_end;

  // memory write repeats the colour, a zero count still writes once
  assign first_reps = (cmd_word[31:24] == CMD_MEM_WRITE && pixel_count != '0) ?
                      pixel_count : pix_count_t'(1);
  assign slot_end = (timer == T_LAST);

  assign write_ok = (state == IDLE);
  assign lcd_cs_n = (state == IDLE);
  assign lcd_wr_n = (state == IDLE) || (timer >= T_HALF);  // strobe low in first half
  assign lcd_rs = (state == DATA);
  assign lcd_data = (state == CMD) ? {8'h00, cmd_q} : param_q;

  always_ff @(posedge pclk) begin
    if (!rst_n) begin
      state <= IDLE;
      timer <= '0;
      reps <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (cmd_valid) begin
            timer <= '0;
            reps <= first_reps;
            // sub-index zero means the command byte goes out first
            state <= (cmd_word[23:16] == 8'h00) ? CMD : DATA;
          end
        end
        CMD: begin
          if (slot_end) begin
            timer <= '0;
            state <= DATA;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        DATA: begin
          if (slot_end) begin
            timer <= '0;
            if (reps == pix_count_t'(1)) begin
              state <= IDLE;
            end else begin
              reps <= reps - 1'b1;
            end
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // command fields held for the whole word
  always_ff @(posedge pclk) begin
    if (state == IDLE && cmd_valid) begin
      cmd_q <= cmd_word[31:24];
      param_q <= cmd_word[15:0];
    end
  end

endmodule

// File: lcd_pkg.sv
// lcd_draw shared types, register offsets and FSM state encodings
package lcd_pkg;

  // one AXI data word, also the layout of a panel command word
  // [31:24] command byte, [23:16] sub-index, [15:0] parameter
  typedef logic [31:0] lcd_word_t;

  typedef logic [3:0] lcd_addr_t;    // byte offset inside the slave window
  typedef logic [15:0] pix_data_t;   // 8080 data bus value
  typedef logic [31:0] pix_count_t;  // pixels per memory write

  // register map
  localparam lcd_addr_t REG_DATA = 4'h0;    // drawing words, write only
  localparam lcd_addr_t REG_TOUCH = 4'h4;   // touch/input value, read only
  localparam lcd_addr_t REG_STATUS = 4'h8;  // bit 0 busy

  localparam logic [7:0] CMD_MEM_WRITE = 8'h2c;  // panel memory write

  // six commands plus the pixel count
  localparam int GRAPH_WORDS = 7;

  typedef enum logic [1:0] {
    FILL,
    DISPATCH,
    DRAIN
  } buf_state_t;

  typedef enum logic [1:0] {
    IDLE,
    CMD,
    DATA
  } pw_state_t;

endpackage

// File: lcd_top.sv
// lcd_draw top, AXI4-Lite slave, graph buffer and 8080 panel writer
module lcd_top
  import lcd_pkg::*;
#(
  parameter int WR_CYCLES = 2,
  parameter int GAP_CYCLES = 2
) (
  input  logic       pclk,
  input  logic       rst_n,

  input  lcd_addr_t  awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  lcd_word_t  wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  lcd_addr_t  araddr,
  input  logic       arvalid,
  output logic       arready,
  output lcd_word_t  rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,

  output logic       lcd_cs_n,
  output logic       lcd_rs,
  output logic       lcd_wr_n,
  output pix_data_t  lcd_data,
  input  lcd_word_t  lcd_input_data
);

  logic push;
  lcd_word_t push_data;
  logic full;
  logic cmd_valid;
  lcd_word_t cmd_word;
  pix_count_t pixel_count;
  logic write_ok;

  lcd_axi_slave u_slave (
    .pclk, .rst_n,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .lcd_input_data,
    .full, .push, .push_data
  );

  lcd_graph_buffer #(.GAP_CYCLES(GAP_CYCLES)) u_buffer (
    .pclk, .rst_n,
    .push, .push_data, .full,
    .write_ok, .cmd_valid, .cmd_word, .pixel_count
  );

  lcd_panel_writer #(.WR_CYCLES(WR_CYCLES)) u_writer (
    .pclk, .rst_n,
    .cmd_valid, .cmd_word, .pixel_count, .write_ok,
    .lcd_cs_n, .lcd_rs, .lcd_wr_n, .lcd_data
  );

endmodule

// File: lcd_top_chk.sv
// lcd_top assertion checker, AXI response hold and panel strobe rules
module lcd_top_chk (
  input logic pclk,
  input logic rst_n,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready,
  input logic lcd_cs_n,
  input logic lcd_wr_n,
  input logic cmd_valid,
  input logic write_ok
);
  timeunit 1ns;
  timeprecision 1ps;

  int fails = 0;  // read by the testbench at the end

  // responses held until taken
  bvalid_hold: assert property (@(posedge pclk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
    else begin fails++; $error("bvalid dropped before bready"); end
  rvalid_hold: assert property (@(posedge pclk) disable iff (!rst_n) rvalid && !rready |=> rvalid)
    else begin fails++; $error("rvalid dropped before rready"); end

  strobe_in_cs: assert property (@(posedge pclk) disable iff (!rst_n) !lcd_wr_n |-> !lcd_cs_n)
    else begin fails++; $error("lcd_wr_n low while lcd_cs_n high"); end

  // writer must be idle when a command is handed over
  dispatch_idle: assert property (@(posedge pclk) disable iff (!rst_n) cmd_valid |-> write_ok)
    else begin fails++; $error("cmd_valid while write_ok low"); end

endmodule

// File: tb_lcd_top.sv
// lcd_draw testbench, drawings over AXI4-Lite checked against a panel bus model
module tb_lcd_top
  import lcd_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int WR_CYCLES = 1;
  localparam int GAP_CYCLES = 2;
  localparam int DRAWINGS = 9;  // reference, five random, two back-pressure, one status
  // worst drawing is six words of one command and seven data cycles each
  localparam int LIMIT = DRAWINGS * (48 * 2 * WR_CYCLES + 6 * (GAP_CYCLES + 2) + 7 * 5) + 400;

  logic pclk;
  logic rst_n;
  lcd_addr_t awaddr;
  lcd_addr_t araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  lcd_word_t wdata;
  lcd_word_t rdata;
  lcd_word_t lcd_input_data;
  logic [1:0] bresp;
  logic [1:0] rresp;
  logic lcd_cs_n, lcd_rs, lcd_wr_n;
  pix_data_t lcd_data;

  logic [31:0] lfsr;
  lcd_word_t draw_w [GRAPH_WORDS];
  logic [17:0] seen[$];   // {cs_n, rs, data} per write strobe
  logic [17:0] exp_q[$];
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int cycles = 0;
  logic wr_n_last = 1'b1;

  lcd_top #(.WR_CYCLES(WR_CYCLES), .GAP_CYCLES(GAP_CYCLES)) UUT (.*);

  bind lcd_top lcd_top_chk chk (.pclk, .rst_n, .bvalid, .bready, .rvalid, .rready,
                                .lcd_cs_n, .lcd_wr_n, .cmd_valid, .write_ok);

  initial begin
    pclk = 1'b0;
    forever #50 pclk = ~pclk;
  end

  always @(posedge pclk) begin
    cycles = cycles + 1;
    if (cycles >= LIMIT) begin
      $display("timeout after %0d cycles, a drawing never finished", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  // panel monitor, data latched by the panel on the rising strobe
  always @(negedge pclk) begin
    if (rst_n && !wr_n_last && lcd_wr_n) begin
      seen.push_back({lcd_cs_n, lcd_rs, lcd_data});
    end
    wr_n_last <= lcd_wr_n;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    checks++;
    if (got !== want) begin
      errors++;
      $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, want);
    end
  endtask

  task automatic next_drive_slot();
    @(posedge pclk);
    #1;
  endtask

  task automatic axi_write(input lcd_addr_t addr, input lcd_word_t data, output logic [1:0] resp);
    next_drive_slot();
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    bready = 1'b0;
    @(negedge pclk);
    while (!(awready && wready)) @(negedge pclk);
    next_drive_slot();
    awvalid = 1'b0;
    wvalid = 1'b0;
    @(negedge pclk);
    while (!bvalid) @(negedge pclk);
    resp = bresp;
    next_drive_slot();  // response stalls one cycle before it is taken
    bready = 1'b1;
  endtask

  task automatic axi_read(input lcd_addr_t addr, output lcd_word_t data, output logic [1:0] resp);
    next_drive_slot();
    araddr = addr;
    arvalid = 1'b1;
    rready = 1'b0;
    @(negedge pclk);
    while (!arready) @(negedge pclk);
    next_drive_slot();
    arvalid = 1'b0;
    @(negedge pclk);
    while (!rvalid) @(negedge pclk);
    data = rdata;
    resp = rresp;
    next_drive_slot();
    rready = 1'b1;
  endtask

  // command word rule, optional command cycle then the parameter, repeated for 8'h2c
  task automatic expand(input lcd_word_t w, input pix_count_t count);
    int n;
    n = 1;
    if (w[31:24] == CMD_MEM_WRITE && count != '0) n = int'(count);
    if (w[23:16] == 8'h00) exp_q.push_back({1'b0, 1'b0, 8'h00, w[31:24]});
    repeat (n) exp_q.push_back({1'b0, 1'b1, w[15:0]});
  endtask

  task automatic model_drawing();
    for (int i = 0; i < GRAPH_WORDS - 1; i++) expand(draw_w[i], draw_w[GRAPH_WORDS-1]);
  endtask

  task automatic random_drawing();
    logic [31:0] sel, cmd, sub, par, cnt;
    for (int i = 0; i < GRAPH_WORDS - 1; i++) begin
      take_bits(2, sel);
      take_bits(8, cmd);
      take_bits(1, sub);
      take_bits(16, par);
      draw_w[i] = {(sel[1:0] == 2'd0) ? CMD_MEM_WRITE : cmd[7:0], sub[0] ? 8'h02 : 8'h00,
                   par[15:0]};
    end
    take_bits(3, cnt);
    draw_w[GRAPH_WORDS-1] = cnt;
  endtask

  task automatic send_words(input int first, input int last);
    logic [1:0] resp;
    for (int i = first; i <= last; i++) begin
      axi_write(REG_DATA, draw_w[i], resp);
      check("bresp", 32'(resp), 32'(2'b00));
    end
  endtask

  task automatic expect_status(input logic busy);
    lcd_word_t d;
    logic [1:0] r;
    axi_read(REG_STATUS, d, r);
    check("status rdata", d, 32'(busy));
  endtask

  // end of a drawing shows as status bit 0 low
  task automatic wait_idle();
    lcd_word_t d;
    logic [1:0] r;
    axi_read(REG_STATUS, d, r);
    while (d[0]) axi_read(REG_STATUS, d, r);
  endtask

  task automatic compare_panel();
    check("panel cycle count", 32'(seen.size()), 32'(exp_q.size()));
    foreach (exp_q[i]) begin
      if (i < seen.size()) check("lcd_cs_n/lcd_rs/lcd_data", 32'(seen[i]), 32'(exp_q[i]));
    end
    check("lcd_cs_n after drawing", 32'(lcd_cs_n), 32'd1);
    seen.delete();
    exp_q.delete();
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errs_before);
  endtask

  initial begin
    lcd_word_t d;
    logic [1:0] r;
    logic [31:0] v;
    int e;
    rst_n = 1'b0;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b1;
    lcd_input_data = '0;
    lfsr = 32'h3136_c791;
    repeat (5) @(posedge pclk);
    #1;
    rst_n = 1'b1;

    e = errors;
    check("lcd_cs_n after reset", 32'(lcd_cs_n), 32'd1);
    check("lcd_wr_n after reset", 32'(lcd_wr_n), 32'd1);
    draw_w = '{32'h2a00_0000, 32'h2a02_00ef, 32'h2b00_0000, 32'h2b02_013f,
               32'h2c00_f800, 32'h2900_0000, 32'd5};
    model_drawing();
    send_words(0, GRAPH_WORDS - 1);
    wait_idle();
    compare_panel();
    end_test("reference drawing", e);

    e = errors;
    repeat (5) begin
      random_drawing();
      model_drawing();
      send_words(0, GRAPH_WORDS - 1);
      wait_idle();
      compare_panel();
    end
    end_test("random drawings", e);

    e = errors;
    random_drawing();
    model_drawing();
    send_words(0, GRAPH_WORDS - 1);
    random_drawing();
    send_words(0, 0);  // held until the first drawing is out
    check("panel cycles at held store", 32'(seen.size()), 32'(exp_q.size()));
    expect_status(1'b0);
    model_drawing();
    send_words(1, GRAPH_WORDS - 1);
    wait_idle();
    compare_panel();
    end_test("back-pressure", e);

    e = errors;
    next_drive_slot();
    take_bits(32, v);
    lcd_input_data = v;
    axi_read(REG_TOUCH, d, r);
    check("touch rdata", d, v);
    check("touch rresp", 32'(r), 32'(2'b00));
    random_drawing();
    model_drawing();
    send_words(0, GRAPH_WORDS - 1);
    expect_status(1'b1);
    wait_idle();
    expect_status(1'b0);
    compare_panel();
    end_test("register reads", e);

    e = errors;
    take_bits(32, v);
    axi_write(4'hc, v, r);
    check("unmapped bresp", 32'(r), 32'(2'b10));
    axi_read(4'hc, d, r);
    check("unmapped rresp", 32'(r), 32'(2'b10));
    expect_status(1'b0);
    repeat (8) @(posedge pclk);
    check("panel cycles after unmapped access", 32'(seen.size()), 32'd0);
    end_test("unmapped offset", e);

    if (UUT.chk.fails != 0) $display("%0d assertion failures", UUT.chk.fails);
    errors += UUT.chk.fails;
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
